// File: verilog/stream_pkg.sv
package stream_pkg;

	// beat format on both stream ports
	localparam int DATA_WIDTH = 64;
	localparam int KEEP_WIDTH = DATA_WIDTH / 8;	// one enable per byte

	// packet buffer sizing
	localparam int PKT_FIFO_DEPTH = 16;	// in beats

	// in_ready drops once this few entries are left, so the beat already
	// in flight on the input still finds room
	localparam int PKT_FIFO_MARGIN = 2;

	// 73 bits
	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic [KEEP_WIDTH-1:0] keep;
		logic                  last;	// closes the packet
	} beat_t;

endpackage

// File: verilog/phv_pkg.sv
package phv_pkg;

	// header fields inside the first beat of a packet
	localparam int DST_PORT_LSB = 48;	// data bits 63:48
	localparam int META_LSB = 32;	// data bits 47:32

	// header vector, 32 bits
	typedef struct packed {
		logic [15:0] dst_port;	// match key, read only in the stages
		logic [15:0] meta;	// rewritten by the actions
	} phv_t;

	localparam int NUM_STAGES = 5;

	// more than the packets the beat buffer can hold at once
	localparam int PHV_FIFO_DEPTH = 32;

	// fixed match table, one entry per stage
	// stages 1 and 3 share a key
	localparam logic [15:0] STAGE_KEY [NUM_STAGES] = '{
		16'h1f90, 16'h0050, 16'h01bb, 16'h0050, 16'h0035
	};

	// addend on a hit, applied modulo 2^16
	localparam logic [15:0] STAGE_ADD [NUM_STAGES] = '{
		16'h0011, 16'h0100, 16'h2000, 16'h0003, 16'hfff0
	};

endpackage

// File: verilog/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int depth = 16	// power of two
) (
	input  logic     clk,
	input  logic     aresetn,
	input  logic     wr_en,
	input  payload_t wr_data,
	input  logic     rd_en,
	output payload_t rd_data,
	output logic     empty,
	output logic     nearly_full
);

	localparam int addr_w = $clog2(depth);

	payload_t mem [depth];
	logic [addr_w-1:0] wr_ptr;
	logic [addr_w-1:0] rd_ptr;
	logic [addr_w:0] count;	// one bit wider to hold depth
	logic do_wr;
	logic do_rd;

	assign empty = (count == '0);
	assign nearly_full = (int'(count) >= depth - stream_pkg::PKT_FIFO_MARGIN);
	assign do_wr = wr_en && (int'(count) != depth);	// drop writes when full
	assign do_rd = rd_en && !empty;
	assign rd_data = mem[rd_ptr];	// head shown without latency

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;	// wraps at depth
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

// File: verilog/header_parser.sv
`timescale 1ns/10ps

module header_parser (
	input  logic              clk,
	input  logic              aresetn,
	input  stream_pkg::beat_t in_beat,
	input  logic              accept,
	output phv_pkg::phv_t     phv,
	output logic              phv_valid
);

	logic sop;	// next accepted beat opens a packet
	logic take_hdr;

	assign take_hdr = accept && sop;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			sop <= 1'b1;
			phv_valid <= 1'b0;
		end else begin
			phv_valid <= take_hdr;	// one cycle pulse
			if (accept)
				sop <= in_beat.last;
		end
	end

	// header fields only from the first beat
	always_ff @(posedge clk) begin
		if (take_hdr) begin
			phv.dst_port <= in_beat.data[phv_pkg::DST_PORT_LSB +: 16];
			phv.meta <= in_beat.data[phv_pkg::META_LSB +: 16];
		end
	end

endmodule

// File: verilog/action_stage.sv
`timescale 1ns/10ps

module action_stage #(
	parameter int stage_idx = 0
) (
	input  logic          clk,
	input  logic          aresetn,
	input  phv_pkg::phv_t phv_in,
	input  logic          phv_in_valid,
	output phv_pkg::phv_t phv_out,
	output logic          phv_out_valid
);

	logic hit;

	assign hit = (phv_in.dst_port == phv_pkg::STAGE_KEY[stage_idx]);

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn)
			phv_out_valid <= 1'b0;
		else
			phv_out_valid <= phv_in_valid;
	end

	// no stall here, a new header may enter every cycle
	always_ff @(posedge clk) begin
		phv_out.dst_port <= phv_in.dst_port;
		if (hit)
			phv_out.meta <= phv_in.meta + phv_pkg::STAGE_ADD[stage_idx];	// wraps at 16 bits
		else
			phv_out.meta <= phv_in.meta;
	end

endmodule

// File: verilog/header_deparser.sv
`timescale 1ns/10ps

module header_deparser (
	input  logic              clk,
	input  logic              aresetn,
	input  stream_pkg::beat_t pkt_head,
	input  logic              pkt_empty,
	output logic              pkt_pop,
	input  phv_pkg::phv_t     phv_head,
	input  logic              phv_empty,
	output logic              phv_pop,
	output stream_pkg::beat_t out_beat,
	output logic              out_valid,
	input  logic              out_ready
);

	logic sop;	// next popped beat is a first beat
	logic slot_free;
	logic src_ready;
	stream_pkg::beat_t next_beat;

	// output register empty or being drained this cycle
	assign slot_free = !out_valid || out_ready;

	// first beat needs its header vector too
	assign src_ready = !pkt_empty && (!sop || !phv_empty);

	assign pkt_pop = slot_free && src_ready;
	assign phv_pop = pkt_pop && sop;

	always_comb begin
		next_beat = pkt_head;
		if (sop)
			next_beat.data[phv_pkg::META_LSB +: 16] = phv_head.meta;
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			sop <= 1'b1;
			out_valid <= 1'b0;
		end else begin
			if (pkt_pop) begin
				out_valid <= 1'b1;
				sop <= pkt_head.last;
			end else if (out_ready) begin
				out_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pkt_pop)
			out_beat <= next_beat;	// held while stalled
	end

endmodule

// File: verilog/rmt_pipe.sv
`timescale 1ns/10ps

module rmt_pipe (
	input  logic              clk,
	input  logic              aresetn,
	input  stream_pkg::beat_t in_beat,
	input  logic              in_valid,
	output logic              in_ready,
	output stream_pkg::beat_t out_beat,
	output logic              out_valid,
	input  logic              out_ready
);

	logic accept;
	logic pkt_nearly_full;
	logic pkt_empty;
	logic pkt_pop;
	stream_pkg::beat_t pkt_head;

	// index 0 is the parser output, index NUM_STAGES the last stage
	phv_pkg::phv_t stg_phv [phv_pkg::NUM_STAGES+1];
	logic stg_valid [phv_pkg::NUM_STAGES+1];

	logic phv_empty;
	logic phv_pop;
	phv_pkg::phv_t phv_head;

	assign in_ready = !pkt_nearly_full;	// level, not a handshake reply
	assign accept = in_valid && in_ready;

	sync_fifo #(
		.payload_t(stream_pkg::beat_t),
		.depth(stream_pkg::PKT_FIFO_DEPTH)
	) pkt_fifo (
		.clk(clk), .aresetn(aresetn),
		.wr_en(accept), .wr_data(in_beat),
		.rd_en(pkt_pop), .rd_data(pkt_head),
		.empty(pkt_empty), .nearly_full(pkt_nearly_full)
	);

	header_parser parser0 (
		.clk(clk), .aresetn(aresetn),
		.in_beat(in_beat), .accept(accept),
		.phv(stg_phv[0]), .phv_valid(stg_valid[0])
	);

	for (genvar i = 0; i < phv_pkg::NUM_STAGES; i++) begin : g_stage
		action_stage #(.stage_idx(i)) stage (
			.clk(clk), .aresetn(aresetn),
			.phv_in(stg_phv[i]), .phv_in_valid(stg_valid[i]),
			.phv_out(stg_phv[i+1]), .phv_out_valid(stg_valid[i+1])
		);
	end

	// deep enough that its fill level never matters
	sync_fifo #(
		.payload_t(phv_pkg::phv_t),
		.depth(phv_pkg::PHV_FIFO_DEPTH)
	) phv_fifo (
		.clk(clk), .aresetn(aresetn),
		.wr_en(stg_valid[phv_pkg::NUM_STAGES]), .wr_data(stg_phv[phv_pkg::NUM_STAGES]),
		.rd_en(phv_pop), .rd_data(phv_head),
		.empty(phv_empty), .nearly_full()
	);

	header_deparser deparser0 (
		.clk(clk), .aresetn(aresetn),
		.pkt_head(pkt_head), .pkt_empty(pkt_empty), .pkt_pop(pkt_pop),
		.phv_head(phv_head), .phv_empty(phv_empty), .phv_pop(phv_pop),
		.out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready)
	);

endmodule

// File: bench/rmt_properties.sv
`timescale 1ns/10ps

module rmt_properties (
	input logic              clk,
	input logic              aresetn,
	input stream_pkg::beat_t in_beat,
	input logic              in_valid,
	input logic              in_ready,
	input stream_pkg::beat_t out_beat,
	input logic              out_valid,
	input logic              out_ready
);

	int fail_count = 0;

	// held beat must not move under back-pressure
	stall_stable: assert property (@(posedge clk) disable iff (!aresetn)
		out_valid && !out_ready |=> out_valid && $stable(out_beat))
	else begin
		fail_count++;
		$error("out_beat changed or out_valid dropped while stalled");
	end

	// a beat offered while in_ready is low is not taken and stays offered
	hold_until_ready: assert property (@(posedge clk) disable iff (!aresetn)
		in_valid && !in_ready |=> in_valid && $stable(in_beat))
	else begin
		fail_count++;
		$error("input beat dropped or changed while in_ready was low");
	end

	// first cycle out of reset
	reset_state: assert property (@(posedge clk) $rose(aresetn) |-> !out_valid && in_ready)
	else begin
		fail_count++;
		$error("wrong output state right after reset");
	end

endmodule

bind rmt_pipe rmt_properties props0 (
	.clk(clk), .aresetn(aresetn), .in_beat(in_beat), .in_valid(in_valid),
	.in_ready(in_ready), .out_beat(out_beat), .out_valid(out_valid),
	.out_ready(out_ready)
);

// File: bench/rmt_checker.sv
`timescale 1ns/10ps

module rmt_checker (
	input  logic              clk,
	input  logic              aresetn,
	input  stream_pkg::beat_t out_beat,
	input  logic              out_valid,
	input  logic              out_ready,
	output int                expected_beats,
	output int                beats_seen,
	output int                mismatches,
	output int                extra_beats,
	output logic              done
);

	localparam int STIM_LINES = 32;

	logic [63:0] stim_words [3*STIM_LINES];
	stream_pkg::beat_t expected [$];

	// meta after the whole stage chain
	function automatic logic [15:0] predict_meta(input logic [15:0] dst_port,
			input logic [15:0] meta);
		logic [15:0] m;
		m = meta;
		for (int s = 0; s < phv_pkg::NUM_STAGES; s++) begin
			if (dst_port == phv_pkg::STAGE_KEY[s])
				m = m + phv_pkg::STAGE_ADD[s];	// mod 2^16
		end
		return m;
	endfunction

	initial begin
		stream_pkg::beat_t b;
		bit sop;
		int i;
		expected_beats = 0;
		beats_seen = 0;
		mismatches = 0;
		extra_beats = 0;
		sop = 1'b1;
		for (i = 0; i < 3*STIM_LINES; i++)
			stim_words[i] = {32'hffffffff, i};	// keep word above 8 bits marks the end
		$readmemh("bench/stim_packets.txt", stim_words);
		for (i = 0; i < STIM_LINES && stim_words[3*i+1] <= 64'hff; i++) begin
			b.data = stim_words[3*i];
			b.keep = stim_words[3*i+1][7:0];
			b.last = stim_words[3*i+2][0];
			if (b.keep != '0) begin
				if (sop)
					b.data[47:32] = predict_meta(b.data[63:48], b.data[47:32]);
				sop = b.last;
				expected.push_back(b);
				expected_beats++;
			end
		end
	end

	assign done = (expected_beats > 0) && (beats_seen >= expected_beats);

	// compared on negedge while outputs are settled
	always @(negedge clk) begin
		stream_pkg::beat_t exp_beat;
		if (aresetn && out_valid && out_ready) begin
			if (expected.size() == 0) begin
				extra_beats++;
				$display("extra output beat at %0t after all expected beats",
					$time);
			end else begin
				exp_beat = expected.pop_front();
				if (out_beat !== exp_beat) begin
					mismatches++;
					$display("Mismatch at %0t: beat %0d got %h/%h/%b, expected %h/%h/%b",
						$time, beats_seen, out_beat.data, out_beat.keep, out_beat.last,
						exp_beat.data, exp_beat.keep, exp_beat.last);
				end
				beats_seen++;
			end
		end
	end

endmodule

// File: bench/tb_rmt_pipe.sv
`timescale 1ns/10ps

module tb_rmt_pipe;

	localparam int STIM_LINES = 32;
	localparam int BURST_AFTER = 4;	// accepted beats before the stall burst
	localparam int BURST_LEN = 40;

	logic clk;
	logic aresetn;
	stream_pkg::beat_t in_beat;
	logic in_valid;
	logic in_ready;
	stream_pkg::beat_t out_beat;
	logic out_valid;
	logic out_ready;

	logic [63:0] stim_words [3*STIM_LINES];	// data, keep, last per line
	logic [31:0] rnd;
	int cycles;
	int cycle_limit;
	int burst_end;
	int beats_sent;
	int tb_errors;
	bit timed_out;
	bit saw_in_ready_low;

	int expected_beats;
	int beats_seen;
	int mismatches;
	int extra_beats;
	logic done;

	rmt_pipe dut0 (
		.clk(clk), .aresetn(aresetn),
		.in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
		.out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready)
	);

	rmt_checker chk0 (
		.clk(clk), .aresetn(aresetn),
		.out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready),
		.expected_beats(expected_beats), .beats_seen(beats_seen),
		.mismatches(mismatches), .extra_beats(extra_beats), .done(done)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// hold the beat until in_ready is seen high before an edge
	task automatic send_beat(input stream_pkg::beat_t b);
		in_beat = b;
		in_valid = 1'b1;
		@(negedge clk);
		while (!in_ready)
			@(negedge clk);
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		beats_sent++;
	endtask

	task finish_run();
		int missing;
		int asrt_fails;
		missing = (expected_beats > beats_seen) ? expected_beats - beats_seen : 0;
		asrt_fails = dut0.props0.fail_count;
		if (missing > 0)
			$display("%0d expected beats never left the pipeline", missing);
		if (!saw_in_ready_low) begin
			$display("in_ready never fell during the output stall burst");
			tb_errors++;
		end
		$display("seen %0d/%0d, mismatch %0d, extra %0d, missing %0d, assert %0d, other %0d",
			beats_seen, expected_beats, mismatches, extra_beats, missing, asrt_fails,
			tb_errors);
		if (mismatches + extra_beats + missing + asrt_fails + tb_errors == 0 && !timed_out)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("run timed out after %0d cycles", cycles);
			timed_out = 1'b1;
			tb_errors++;
			finish_run();
		end
	end

	// random back-pressure with a long stall burst
	always @(posedge clk) begin
		#1;
		rnd = xorshift32(rnd);
		if (cycles < burst_end)
			out_ready = 1'b0;
		else
			out_ready = (rnd % 32'd3) != 32'd0;
	end

	always @(negedge clk)
		if (aresetn && cycles < burst_end && !in_ready)
			saw_in_ready_low = 1'b1;

	initial begin
		stream_pkg::beat_t b;
		int n_lines;
		int num_beats;
		int k;
		clk = 1'b0;
		aresetn = 1'b0;
		in_beat = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		rnd = 32'h0115322f;
		cycles = 0;
		cycle_limit = 0;
		burst_end = 0;
		beats_sent = 0;
		tb_errors = 0;
		timed_out = 1'b0;
		saw_in_ready_low = 1'b0;
		for (k = 0; k < 3*STIM_LINES; k++)
			stim_words[k] = {32'hffffffff, k};	// keep word over 8 bits marks the end
		$readmemh("bench/stim_packets.txt", stim_words);
		n_lines = 0;
		num_beats = 0;
		while (n_lines < STIM_LINES && stim_words[3*n_lines+1] <= 64'hff) begin
			if (stim_words[3*n_lines+1] != 64'h0)
				num_beats++;
			n_lines++;
		end
		if (num_beats == 0) begin
			$display("no stimulus beats found in bench/stim_packets.txt");
			tb_errors++;
		end
		cycle_limit = 40 * num_beats + 200;
		repeat (8) @(posedge clk);
		#1;
		aresetn = 1'b1;
		for (k = 0; k < n_lines; k++) begin
			b.data = stim_words[3*k];
			b.keep = stim_words[3*k+1][7:0];
			b.last = stim_words[3*k+2][0];
			if (b.keep == '0) begin
				@(posedge clk);	// idle cycle
				#1;
			end else begin
				send_beat(b);
				if (beats_sent == BURST_AFTER)
					burst_end = cycles + BURST_LEN;
			end
		end
		while (!done)
			@(posedge clk);
		finish_run();
	end

endmodule

// File: bench/stim_packets.txt
// one beat per line: data (64-bit hex), keep, last
// keep 00 marks an idle input cycle, not a beat
00501234a1a10001 ff 0
111122223333a102 ff 0
444455556666a103 0f 1
1f90beefb2b20001 ff 1
01bb0042c3c30001 ff 1
00350020d4d40001 ff 1
77770abce5e50001 7f 1
0000000000000000 00 0
0050fffff6f60001 ff 0
a5a5a5a5a5a5f602 ff 0
5a5a5a5a5a5af603 ff 0
0123456789abf604 03 1
0000000000000000 00 0
0000000000000000 00 0
0000ffff07070001 ff 0
fedcba9876540702 3f 1
1f9000ef08080001 ff 1
01bb600009090001 ff 0
cafef00dcafe0902 ff 0
deadbeef00000903 01 1
0035000f0a0a0001 ff 0
0102030405060a02 ff 1

// File: sources.f
verilog/stream_pkg.sv
verilog/phv_pkg.sv
verilog/sync_fifo.sv
verilog/header_parser.sv
verilog/action_stage.sv
verilog/header_deparser.sv
verilog/rmt_pipe.sv
bench/rmt_properties.sv
bench/rmt_checker.sv
bench/tb_rmt_pipe.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the rmt_pipe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_rmt_pipe \
	-Mdir obj_dir -o sim_tb

# keep running past assertion errors so the closing line is printed
./obj_dir/sim_tb +verilator+error+limit+100 | tee sim.log

if grep -qx "TEST OK" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi
